// File: Makefile
SIM      = verilator
TOP      = branchStationTb
FILELIST = branchStation.f
FLAGS    = --binary --timing --top-module $(TOP)
OBJDIR   = obj_dir

BIN  = $(OBJDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// File: branchStation.f
hdl/branchRsPkg.sv
hdl/branchRsEntry.sv
hdl/branchSelect.sv
hdl/branchResolve.sv
hdl/branchStation.sv
dv/branchStationTb.sv

// File: dv/branchStationPatterns.mem
// kind tag op v1 r1 t1 v2 r2 t2 predPc tgtAddr seqAddr | expActualPc expLink expTaken expMisp
// kind 0 dispatch, 1 cdb (tag, v1), 2 dispatch with cdb (t1, v1), 3 flush, 4 drain,
// kind 5 stalled dispatch freed by cdb (t1, t2), f end of patterns
0 0 0 5 1 0 5 1 0 1100 1100 1004 1100 0 1 0
0 1 1 5 1 0 5 1 0 2200 2200 2004 2004 0 0 1
0 2 2 ffffffff 1 0 1 1 0 3004 3100 3004 3100 0 1 1
0 3 3 ffffffff 1 0 1 1 0 4004 4100 4004 4004 0 0 0
0 4 4 ffffffff 1 0 1 1 0 5100 5100 5004 5004 0 0 1
0 5 5 ffffffff 1 0 1 1 0 6100 6100 6004 6100 0 1 0
0 6 6 0 1 0 0 1 0 7200 7200 7004 7200 7004 1 0
0 7 7 8001 1 0 10 1 0 8000 0 9004 8010 9004 1 1
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 2 0 0 5 10 1 0 a100 a100 a004 a100 0 1 0
0 1 5 0 0 5 0 0 6 b004 b100 b004 b100 0 1 1
1 5 0 fffffff0 0 0 0 0 0 0 0 0 0 0 0 0
1 6 0 20 0 0 0 0 0 0 0 0 0 0 0 0
2 2 0 33 0 6 33 1 0 c100 c100 c004 c100 0 1 0
2 3 7 d001 0 6 4 1 0 d004 0 e008 d004 e008 1 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 0 0 4 7 1 0 f100 f100 f004 f100 0 1 0
0 1 4 0 0 4 7 1 0 10100 10100 10004 10004 0 0 1
0 2 3 0 0 4 fffffff0 1 0 11004 11100 11004 11100 0 1 1
0 3 6 0 0 4 0 1 0 12200 12200 12004 12200 12004 1 0
5 5 0 1 1 4 9 1 9 13100 13100 13004 13100 0 1 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 7 0 1 0 0 0 0 0 0 0 0
0 1 1 0 1 0 0 0 7 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 2 0 0 1 0 0 1 0 14100 14100 14004 14100 0 1 0
0 3 6 0 1 0 0 1 0 15000 15200 15004 15200 15004 1 1
f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: dv/branchStationTb.sv
`timescale 1ns/1ps
/*
  testbench for the branch reservation station
  clock, reset, pattern-driven dispatch and CDB, ROB-side handshake, scoreboard, watchdog
*/
module branchStationTb import branchRsPkg::*; ();

  localparam int maxRecords = 64;
  localparam int recWords   = 16;   // words per pattern line
  localparam int cycleNs    = 100;

  logic     clk;
  logic     arstN;
  logic     flush;
  logic     dispatchReq;
  dispatchT dispatch;
  cdbT      cdb;
  logic     resolveAck;
  logic     dispatchAck;
  logic     resolveReq;
  resolveT  resolution;

  logic [31:0] pat [0:maxRecords*recWords-1];
  resolveT     expRes [8];        // expected outcome per ROB tag
  logic  [7:0] pending;           // tag dispatched, not yet resolved
  logic  [7:0] forbidden;         // tag squashed by flush
  int          pendingCount;
  int          recordCount;

  branchStation #(.numEntries(4)) branchStation_inst (
    .clk         (clk),
    .arstN       (arstN),
    .flush       (flush),
    .dispatchReq (dispatchReq),
    .dispatch    (dispatch),
    .cdb         (cdb),
    .resolveAck  (resolveAck),
    .dispatchAck (dispatchAck),
    .resolveReq  (resolveReq),
    .resolution  (resolution)
  );

  always #50 clk = ~clk;

  task automatic stopRun(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #5; // drive and sample away from the edge
  endtask

  function automatic dispatchT makeDispatch(input int b);
    dispatchT d;
    d.robTag      = robTagT'(pat[b+1]);
    d.op          = branchOpT'(pat[b+2][2:0]);
    d.value1      = pat[b+3];
    d.ready1      = pat[b+4][0];
    d.tag1        = robTagT'(pat[b+5]);
    d.value2      = pat[b+6];
    d.ready2      = pat[b+7][0];
    d.tag2        = robTagT'(pat[b+8]);
    d.predictedPc = pat[b+9];
    d.targetAddr  = pat[b+10];
    d.seqAddr     = pat[b+11];
    return d;
  endfunction

  task automatic recordExpected(input int b);
    robTagT t;
    t = robTagT'(pat[b+1]);
    assert (!pending[t]) else stopRun($sformatf("pattern reuses ROB tag %0h still in flight", t));
    expRes[t].robTag     = t;
    expRes[t].actualPc   = pat[b+12];
    expRes[t].linkValue  = pat[b+13];
    expRes[t].taken      = pat[b+14][0];
    expRes[t].mispredict = pat[b+15][0];
    pending[t]   = 1'b1;
    forbidden[t] = 1'b0;
    pendingCount++;
  endtask

  task automatic broadcast(input robTagT t, input dataT v);
    cdb = '{valid: 1'b1, robEntry: t, result: v};
    nextCycle();
    cdb.valid = 1'b0; // exactly one cycle
  endtask

  // four-phase dispatch, optional CDB in the request cycle
  task automatic dispatchOne(input dispatchT d, input logic withCdb, input robTagT t,
                             input dataT v);
    dispatch    = d;
    dispatchReq = 1'b1;
    if (withCdb) cdb = '{valid: 1'b1, robEntry: t, result: v};
    nextCycle();
    cdb.valid = 1'b0;
    while (!dispatchAck) nextCycle();
    dispatchReq = 1'b0;
    while (dispatchAck) nextCycle();
  endtask

  // request into a full station, then free it with a broadcast
  task automatic dispatchStalled(input dispatchT d, input robTagT t, input dataT v);
    dispatch    = d;
    dispatchReq = 1'b1;
    repeat (4) begin
      nextCycle();
      assert (!dispatchAck) else stopRun("dispatch acknowledged while the station was full");
    end
    broadcast(t, v);
    while (!dispatchAck) nextCycle();
    dispatchReq = 1'b0;
    while (dispatchAck) nextCycle();
  endtask

  task automatic drain();
    while (pendingCount != 0 || resolveReq || resolveAck) nextCycle();
    nextCycle();
  endtask

  // ROB side: check and acknowledge each resolution
  initial begin
    robTagT t;
    int     delay;
    resolveAck = 1'b0;
    wait (arstN === 1'b1);
    forever begin
      nextCycle();
      if (resolveReq && !resolveAck) begin
        t = resolution.robTag;
        assert (!forbidden[t]) else stopRun($sformatf("flushed ROB tag %0h was resolved", t));
        assert (pending[t]) else stopRun($sformatf("resolution for ROB tag %0h not in flight", t));
        assert (resolution.actualPc == expRes[t].actualPc) else
          stopRun($sformatf("[FAIL] actualPc tag %0h expected %h got %h", t,
                            expRes[t].actualPc, resolution.actualPc));
        assert (resolution.linkValue == expRes[t].linkValue) else
          stopRun($sformatf("[FAIL] linkValue tag %0h expected %h got %h", t,
                            expRes[t].linkValue, resolution.linkValue));
        assert (resolution.taken == expRes[t].taken) else
          stopRun($sformatf("[FAIL] taken tag %0h expected %h got %h", t,
                            expRes[t].taken, resolution.taken));
        assert (resolution.mispredict == expRes[t].mispredict) else
          stopRun($sformatf("[FAIL] mispredict tag %0h expected %h got %h", t,
                            expRes[t].mispredict, resolution.mispredict));
        pending[t] = 1'b0;
        pendingCount--;
        delay = int'($urandom_range(3, 0));
        repeat (delay) nextCycle();
        resolveAck = 1'b1;
        while (resolveReq) nextCycle();
        resolveAck = 1'b0;
      end
    end
  end

  // watchdog sized from the pattern length
  initial begin
    wait (arstN === 1'b1); // record count settled before reset release
    #(recordCount * 40 * cycleNs);
    $display("run timed out waiting on a handshake");
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    int       b;
    dispatchT d;
    clk          = 1'b0;
    arstN        = 1'b0;
    flush        = 1'b0;
    dispatchReq  = 1'b0;
    dispatch     = '0;
    cdb          = '0;
    pending      = '0;
    forbidden    = '0;
    pendingCount = 0;
    recordCount  = 0;
    void'($urandom(32'h3df9));
    $readmemh("dv/branchStationPatterns.mem", pat);
    while (recordCount < maxRecords && pat[recordCount*recWords] !== 32'hf) recordCount++;
    repeat (2) @(posedge clk);
    #5 arstN = 1'b1;
    nextCycle();
    for (int r = 0; r < recordCount; r++) begin
      b = r * recWords;
      case (pat[b])
        32'd0: begin
          recordExpected(b);
          dispatchOne(makeDispatch(b), 1'b0, '0, '0);
        end
        32'd1: broadcast(robTagT'(pat[b+1]), pat[b+3]);
        32'd2: begin // broadcast lands with the write
          recordExpected(b);
          d = makeDispatch(b);
          d.value1 = ~d.value1; // stale until the forwarded broadcast
          dispatchOne(d, 1'b1, robTagT'(pat[b+5]), pat[b+3]);
        end
        32'd3: begin
          repeat (3) nextCycle();
          flush = 1'b1;
          nextCycle();
          flush = 1'b0;
          forbidden    = forbidden | pending; // all squashed
          pending      = '0;
          pendingCount = 0;
        end
        32'd4: drain();
        32'd5: begin
          recordExpected(b);
          d = makeDispatch(b);
          d.value1 = pat[b+8]; // operand 1 is the result its producer broadcasts
          dispatchStalled(d, robTagT'(pat[b+5]), pat[b+8]);
        end
        default: stopRun($sformatf("unknown pattern record kind %0h", pat[b]));
      endcase
    end
    drain();
    repeat (10) nextCycle(); // give any leaked entry time to show up
    if (pendingCount == 0 && pending == '0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("resolutions missing at end of run");
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

// File: hdl/branchResolve.sv
`timescale 1ns/1ps
/*
  branch resolve unit
  condition compare, actual next PC, link value, misprediction check
  four-phase req/ack toward the ROB
*/
module branchResolve import branchRsPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    issueValid,
  input  issueT   issue,
  input  logic    resolveAck,
  output logic    resolveIdle,
  output logic    resolveReq,
  output resolveT resolution
);

  typedef enum logic [1:0] {idle, request, waitRelease} resolveStateT;

  resolveStateT state;
  resolveT      nextRes;  // outcome of the slot being issued
  dataT         sum;      // jalr base + immediate
  logic         taken;
  addrT         actualPc;
  dataT         linkValue;

  always_comb begin
    sum = issue.src1 + issue.src2;
    unique case (issue.op)
      opBeq:   taken = (issue.src1 == issue.src2);
      opBne:   taken = (issue.src1 != issue.src2);
      opBlt:   taken = ($signed(issue.src1) < $signed(issue.src2));
      opBge:   taken = ($signed(issue.src1) >= $signed(issue.src2));
      opBltu:  taken = (issue.src1 < issue.src2);
      opBgeu:  taken = (issue.src1 >= issue.src2);
      default: taken = 1'b1; // jal / jalr always go
    endcase

    if (issue.op == opJalr) begin
      actualPc  = {sum[31:1], 1'b0}; // bit 0 dropped
      linkValue = issue.seqAddr;
    end else if (issue.op == opJal) begin
      actualPc  = issue.targetAddr;
      linkValue = issue.seqAddr;
    end else begin
      actualPc  = taken ? issue.targetAddr : issue.seqAddr;
      linkValue = '0; // no link for B-type
    end

    nextRes.robTag     = issue.robTag;
    nextRes.actualPc   = actualPc;
    nextRes.linkValue  = linkValue;
    nextRes.taken      = taken;
    nextRes.mispredict = (actualPc != issue.predictedPc);
  end

  assign resolveIdle = (state == idle);
  assign resolveReq  = (state == request);

  // ROB handshake
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= idle;
    end else begin
      unique case (state)
        idle:        if (issueValid) state <= request;
        request:     if (resolveAck) state <= waitRelease; // req drops next
        waitRelease: if (!resolveAck) state <= idle;
        default:     state <= idle;
      endcase
    end
  end

  // held stable for the whole handshake
  always_ff @(posedge clk) begin
    if (state == idle && issueValid) resolution <= nextRes;
  end

endmodule

// File: hdl/branchRsEntry.sv
`timescale 1ns/1ps
/*
  single branch reservation station entry
  holds one instruction, snoops the CDB for pending operands, requests selection
*/
module branchRsEntry import branchRsPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  logic     flush,
  input  logic     write,      // dispatch lands here this edge
  input  dispatchT writeData,
  input  cdbT      cdb,
  input  logic     grant,      // picked by select, leaves this edge
  output logic     busy,
  output logic     selectReq,
  output issueT    entry
);

  logic   ready1, ready2; // operand already captured
  robTagT tag1, tag2;     // producers still owed
  logic   hit1, hit2;     // broadcast matches a stored operand
  logic   fwd1, fwd2;     // broadcast matches the incoming dispatch

  always_comb begin
    hit1 = cdb.valid & busy & ~ready1 & (cdb.robEntry == tag1);
    hit2 = cdb.valid & busy & ~ready2 & (cdb.robEntry == tag2);
    // same-cycle broadcast during the write
    fwd1 = cdb.valid & ~writeData.ready1 & (cdb.robEntry == writeData.tag1);
    fwd2 = cdb.valid & ~writeData.ready2 & (cdb.robEntry == writeData.tag2);
    selectReq = busy & ready1 & ready2; // stored state only
  end

  // control flags
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy   <= 1'b0;
      ready1 <= 1'b0;
      ready2 <= 1'b0;
    end else if (flush) begin
      busy   <= 1'b0; // whole station squashed
      ready1 <= 1'b0;
      ready2 <= 1'b0;
    end else if (write) begin
      busy   <= 1'b1;
      ready1 <= writeData.ready1 | fwd1;
      ready2 <= writeData.ready2 | fwd2;
    end else begin
      if (grant) busy <= 1'b0;   // handed to resolve
      if (hit1) ready1 <= 1'b1;
      if (hit2) ready2 <= 1'b1;
    end
  end

  // payload, valid only while busy
  always_ff @(posedge clk) begin
    if (write) begin
      entry.robTag      <= writeData.robTag;
      entry.op          <= writeData.op;
      entry.src1        <= fwd1 ? cdb.result : writeData.value1;
      entry.src2        <= fwd2 ? cdb.result : writeData.value2;
      entry.predictedPc <= writeData.predictedPc;
      entry.targetAddr  <= writeData.targetAddr;
      entry.seqAddr     <= writeData.seqAddr;
      tag1              <= writeData.tag1;
      tag2              <= writeData.tag2;
    end else begin
      if (hit1) entry.src1 <= cdb.result; // wakeup capture
      if (hit2) entry.src2 <= cdb.result;
    end
  end

endmodule

// File: hdl/branchRsPkg.sv
/*
  shared types for the branch reservation station
  width typedefs, branch opcode enum, dispatch, CDB, issue and resolution bundles
*/
package branchRsPkg;

  typedef logic [31:0] dataT;   // operand / result word
  typedef logic [31:0] addrT;   // instruction address
  typedef logic [2:0]  robTagT; // 8 ROB entries

  typedef enum logic [2:0] {
    opBeq  = 3'd0,
    opBne  = 3'd1,
    opBlt  = 3'd2,
    opBge  = 3'd3,
    opBltu = 3'd4,
    opBgeu = 3'd5,
    opJal  = 3'd6,
    opJalr = 3'd7
  } branchOpT;

  // instruction as it leaves rename, operands may still be pending
  typedef struct packed {
    robTagT   robTag;      // own ROB slot
    branchOpT op;
    dataT     value1;
    logic     ready1;
    robTagT   tag1;        // producer of operand 1 if not ready
    dataT     value2;
    logic     ready2;
    robTagT   tag2;
    addrT     predictedPc; // fetch's guess of the next PC
    addrT     targetAddr;  // B-type and JAL target
    addrT     seqAddr;     // pc + 4
  } dispatchT;

  // one-cycle result broadcast
  typedef struct packed {
    logic   valid;
    robTagT robEntry;
    dataT   result;
  } cdbT;

  // outcome reported back to the ROB
  typedef struct packed {
    robTagT robTag;
    addrT   actualPc;
    dataT   linkValue;  // zero for conditional branches
    logic   taken;
    logic   mispredict;
  } resolveT;

  // entry contents once both operands are known
  typedef struct packed {
    robTagT   robTag;
    branchOpT op;
    dataT     src1;
    dataT     src2;
    addrT     predictedPc;
    addrT     targetAddr;
    addrT     seqAddr;
  } issueT;

endpackage

// File: hdl/branchSelect.sv
`timescale 1ns/1ps
/*
  fixed-priority select over the entry array
  one-hot grant and the registered issue slot feeding the resolve unit
*/
module branchSelect import branchRsPkg::*; #(
  parameter int numEntries = 4
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  flush,
  input  logic [numEntries-1:0] selectReq,
  input  issueT                 entries [numEntries],
  input  logic                  resolveIdle,
  output logic [numEntries-1:0] grant,
  output logic                  issueValid,
  output issueT                 issue
);

  localparam int idxW = (numEntries > 1) ? $clog2(numEntries) : 1;

  typedef enum logic {issueEmpty, issueLoaded} issueStateT;

  issueStateT      state;
  logic [idxW-1:0] pick;     // lowest requesting index
  logic            found;
  logic            canIssue;

  always_comb begin
    found = 1'b0;
    pick  = '0;
    for (int i = numEntries - 1; i >= 0; i--) begin // last hit wins, lowest index
      if (selectReq[i]) begin
        found = 1'b1;
        pick  = idxW'(i);
      end
    end
    // slot empty and resolve free, nothing new during flush
    canIssue = found & resolveIdle & (state == issueEmpty) & ~flush;
    grant = '0;
    if (canIssue) grant[pick] = 1'b1;
  end

  assign issueValid = (state == issueLoaded);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) state <= issueEmpty;
    else if (flush) state <= issueEmpty;
    else if (canIssue) state <= issueLoaded;
    else state <= issueEmpty; // resolve takes it in one cycle
  end

  always_ff @(posedge clk) begin
    if (canIssue) issue <= entries[pick];
  end

endmodule

// File: hdl/branchStation.sv
`timescale 1ns/1ps
/*
  branch reservation station top
  dispatch handshake, free-entry allocation, entry array, select and resolve
*/
module branchStation import branchRsPkg::*; #(
  parameter int numEntries = 4
) (
  input  logic     clk,
  input  logic     arstN,
  input  logic     flush,
  input  logic     dispatchReq,
  input  dispatchT dispatch,
  input  cdbT      cdb,
  input  logic     resolveAck,
  output logic     dispatchAck,
  output logic     resolveReq,
  output resolveT  resolution
);

  localparam int idxW = (numEntries > 1) ? $clog2(numEntries) : 1;

  logic [numEntries-1:0] busy;
  logic [numEntries-1:0] selectReq;
  logic [numEntries-1:0] grant;
  logic [numEntries-1:0] write;      // one-hot write strobe
  issueT                 entries [numEntries];
  issueT                 issue;
  logic                  issueValid;
  logic                  resolveIdle;
  logic [idxW-1:0]       freeIdx;    // lowest free slot
  logic                  anyFree;
  logic                  accept;

  always_comb begin
    anyFree = 1'b0;
    freeIdx = '0;
    for (int i = numEntries - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        anyFree = 1'b1;
        freeIdx = idxW'(i);
      end
    end
    // new req only, stall when full or flushing
    accept = dispatchReq & ~dispatchAck & anyFree & ~flush;
    write  = '0;
    if (accept) write[freeIdx] = 1'b1;
  end

  // ack rises with the write, falls once req is gone
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) dispatchAck <= 1'b0;
    else if (accept) dispatchAck <= 1'b1;
    else if (!dispatchReq) dispatchAck <= 1'b0;
  end

  for (genvar i = 0; i < numEntries; i++) begin : gEntry
    branchRsEntry entryInst (
      .clk       (clk),
      .arstN     (arstN),
      .flush     (flush),
      .write     (write[i]),
      .writeData (dispatch),
      .cdb       (cdb),
      .grant     (grant[i]),
      .busy      (busy[i]),
      .selectReq (selectReq[i]),
      .entry     (entries[i])
    );
  end

  branchSelect #(.numEntries(numEntries)) selectInst (
    .clk         (clk),
    .arstN       (arstN),
    .flush       (flush),
    .selectReq   (selectReq),
    .entries     (entries),
    .resolveIdle (resolveIdle),
    .grant       (grant),
    .issueValid  (issueValid),
    .issue       (issue)
  );

  branchResolve resolveInst (
    .clk         (clk),
    .arstN       (arstN),
    .issueValid  (issueValid),
    .issue       (issue),
    .resolveAck  (resolveAck),
    .resolveIdle (resolveIdle),
    .resolveReq  (resolveReq),
    .resolution  (resolution)
  );

endmodule
